// ==== rtl/afu_pkg.sv ====
package afu_pkg;

	// host control bus
	localparam int CTRL_ADDR_W = 8;
	localparam int CTRL_DATA_W = 32;

	// core memory side
	localparam int NUM_BANKS  = 2;
	localparam int BANK_CNT_W = $clog2(NUM_BANKS + 1);
	localparam int PENDING_W  = 12;

	// core reset hold after start, in cycles
	localparam int RESET_DELAY = 8;
	localparam int RESET_CTR_W = $clog2(RESET_DELAY + 1);

	localparam int DCR_ADDR_W = 12;
	localparam int DCR_DATA_W = 32;

	// register map
	localparam logic [CTRL_ADDR_W-1:0] REG_CTRL     = 8'h00;
	localparam logic [CTRL_ADDR_W-1:0] REG_GIE      = 8'h04;
	localparam logic [CTRL_ADDR_W-1:0] REG_IER      = 8'h08;
	localparam logic [CTRL_ADDR_W-1:0] REG_ISR      = 8'h0C;
	localparam logic [CTRL_ADDR_W-1:0] REG_DCR_ADDR = 8'h10;
	localparam logic [CTRL_ADDR_W-1:0] REG_DCR_DATA = 8'h14;

	// run sequencer states
	localparam int STATE_W = 2;
	localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
	localparam logic [STATE_W-1:0] ST_INIT = 2'd1;
	localparam logic [STATE_W-1:0] ST_RUN  = 2'd2;
	localparam logic [STATE_W-1:0] ST_DONE = 2'd3;

	// control word, seen as raw data or as status bits
	typedef union packed {
		logic [CTRL_DATA_W-1:0] raw;
		struct packed {
			logic [CTRL_DATA_W-4:0] rsvd;
			logic                   idle;
			logic                   done;
			logic                   start;
		} status;
	} ctrl_word_u;

endpackage

// ==== rtl/afu_ctrl_regs.sv ====
`timescale 1ns/10ps

module afu_ctrl_regs import afu_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   ctrl_awvalid,
	output logic                   ctrl_awready,
	input  logic [CTRL_ADDR_W-1:0] ctrl_awaddr,

	input  logic                   ctrl_wvalid,
	output logic                   ctrl_wready,
	input  logic [CTRL_DATA_W-1:0] ctrl_wdata,

	output logic                   ctrl_bvalid,
	input  logic                   ctrl_bready,

	input  logic                   ctrl_arvalid,
	output logic                   ctrl_arready,
	input  logic [CTRL_ADDR_W-1:0] ctrl_araddr,

	output logic                   ctrl_rvalid,
	input  logic                   ctrl_rready,
	output logic [CTRL_DATA_W-1:0] ctrl_rdata,

	input  logic [STATE_W-1:0]     run_state,
	input  logic                   ap_done,

	output logic                   ap_start,
	output logic                   ap_ctrl_read,

	output logic                   dcr_wr_valid,
	output logic [DCR_ADDR_W-1:0]  dcr_wr_addr,
	output logic [DCR_DATA_W-1:0]  dcr_wr_data,

	output logic                   interrupt
);

	logic wr_fire;
	logic rd_fire;
	logic start_req;
	logic gie;
	logic ier;
	logic isr;
	logic ap_done_q;
	logic done_rise;
	ctrl_word_u status_word;
	logic [CTRL_DATA_W-1:0] rd_word;

	// address and data are taken together, one write in flight
	assign ctrl_awready = !ctrl_bvalid;
	assign ctrl_wready  = !ctrl_bvalid;
	assign wr_fire      = ctrl_awvalid && ctrl_wvalid && !ctrl_bvalid;

	assign ctrl_arready = !ctrl_rvalid;
	assign rd_fire      = ctrl_arvalid && !ctrl_rvalid;

	assign done_rise = ap_done && !ap_done_q;

	always_comb begin
		status_word.raw = '0;
		status_word.status.start = (run_state != ST_IDLE) && !ap_done;
		status_word.status.done  = ap_done;
		status_word.status.idle  = (run_state == ST_IDLE);
	end

	always_comb begin
		case (ctrl_araddr)
			REG_CTRL:     rd_word = status_word.raw;
			REG_GIE:      rd_word = CTRL_DATA_W'(gie);
			REG_IER:      rd_word = CTRL_DATA_W'(ier);
			REG_ISR:      rd_word = CTRL_DATA_W'(isr);
			REG_DCR_ADDR: rd_word = CTRL_DATA_W'(dcr_wr_addr);
			REG_DCR_DATA: rd_word = CTRL_DATA_W'(dcr_wr_data);
			default:      rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_bvalid  <= 1'b0;
			ctrl_rvalid  <= 1'b0;
			start_req    <= 1'b0;
			ap_start     <= 1'b0;
			ap_ctrl_read <= 1'b0;
			dcr_wr_valid <= 1'b0;
			gie          <= 1'b0;
			ier          <= 1'b0;
			isr          <= 1'b0;
			ap_done_q    <= 1'b0;
			interrupt    <= 1'b0;
		end else begin
			if (wr_fire) begin
				ctrl_bvalid <= 1'b1;
			end else if (ctrl_bready) begin
				ctrl_bvalid <= 1'b0;
			end

			if (rd_fire) begin
				ctrl_rvalid <= 1'b1;
			end else if (ctrl_rready) begin
				ctrl_rvalid <= 1'b0;
			end

			// start goes out one cycle behind the write
			start_req <= wr_fire && (ctrl_awaddr == REG_CTRL) && ctrl_wdata[0];
			ap_start  <= start_req;

			// only a read that returned done acknowledges it
			ap_ctrl_read <= rd_fire && (ctrl_araddr == REG_CTRL) && ap_done;
			dcr_wr_valid <= wr_fire && (ctrl_awaddr == REG_DCR_DATA);

			if (wr_fire && (ctrl_awaddr == REG_GIE)) begin
				gie <= ctrl_wdata[0];
			end
			if (wr_fire && (ctrl_awaddr == REG_IER)) begin
				ier <= ctrl_wdata[0];
			end

			// a new completion wins over a clear in the same cycle
			if (done_rise) begin
				isr <= 1'b1;
			end else if (wr_fire && (ctrl_awaddr == REG_ISR) && ctrl_wdata[0]) begin
				isr <= 1'b0;
			end

			ap_done_q <= ap_done;
			interrupt <= gie && ier && isr;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire && (ctrl_awaddr == REG_DCR_ADDR)) begin
			dcr_wr_addr <= ctrl_wdata[DCR_ADDR_W-1:0];
		end
		if (wr_fire && (ctrl_awaddr == REG_DCR_DATA)) begin
			dcr_wr_data <= ctrl_wdata[DCR_DATA_W-1:0];
		end
		if (rd_fire) begin
			ctrl_rdata <= rd_word;
		end
	end

endmodule

// ==== rtl/afu_run_seq.sv ====
`timescale 1ns/10ps

module afu_run_seq import afu_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               ap_start,
	input  logic               ap_ctrl_read,
	input  logic               core_busy,
	input  logic               writes_drained,
	output logic [STATE_W-1:0] run_state,
	output logic               ap_done,
	output logic               core_reset
);

	logic [RESET_CTR_W-1:0] reset_ctr;

	// done only once every memory write has been acknowledged
	assign ap_done = (run_state == ST_DONE) && writes_drained;

	always_ff @(posedge clk) begin
		if (reset) begin
			run_state  <= ST_IDLE;
			core_reset <= 1'b1;
			reset_ctr  <= '0;
		end else begin
			case (run_state)
				ST_IDLE: begin
					if (ap_start) begin
						run_state  <= ST_INIT;
						core_reset <= 1'b1;
						reset_ctr  <= RESET_CTR_W'(RESET_DELAY - 1);
					end
				end
				ST_INIT: begin
					if (core_reset) begin
						// hold the core in reset for the full delay
						if (reset_ctr == '0) begin
							core_reset <= 1'b0;
						end else begin
							reset_ctr <= reset_ctr - 1'b1;
						end
					end else if (core_busy) begin
						run_state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (!core_busy) begin
						run_state <= ST_DONE;
					end
				end
				ST_DONE: begin
					// host has read the done status
					if (ap_done && ap_ctrl_read) begin
						run_state  <= ST_IDLE;
						core_reset <= 1'b1;
					end
				end
				default: begin
					run_state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== rtl/afu_write_tracker.sv ====
`timescale 1ns/10ps

module afu_write_tracker import afu_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_BANKS-1:0] mem_awvalid,
	input  logic [NUM_BANKS-1:0] mem_awready,
	input  logic [NUM_BANKS-1:0] mem_wvalid,
	input  logic [NUM_BANKS-1:0] mem_wready,
	input  logic [NUM_BANKS-1:0] mem_bvalid,
	input  logic [NUM_BANKS-1:0] mem_bready,
	output logic                 writes_drained
);

	logic [NUM_BANKS-1:0]  aw_fire;
	logic [NUM_BANKS-1:0]  w_fire;
	logic [NUM_BANKS-1:0]  b_fire;
	logic [NUM_BANKS-1:0]  aw_seen;
	logic [NUM_BANKS-1:0]  w_seen;
	logic [NUM_BANKS-1:0]  tx_done;
	logic [BANK_CNT_W-1:0] req_cnt;
	logic [BANK_CNT_W-1:0] rsp_cnt;
	logic [PENDING_W-1:0]  pending;

	assign aw_fire = mem_awvalid & mem_awready;
	assign w_fire  = mem_wvalid & mem_wready;
	assign b_fire  = mem_bvalid & mem_bready;

	// a transaction is complete once both request halves have been seen
	assign tx_done = (aw_fire | aw_seen) & (w_fire | w_seen);

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_seen <= '0;
			w_seen  <= '0;
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (tx_done[i]) begin
					aw_seen[i] <= 1'b0;
					w_seen[i]  <= 1'b0;
				end else begin
					aw_seen[i] <= aw_seen[i] | aw_fire[i];
					w_seen[i]  <= w_seen[i] | w_fire[i];
				end
			end
		end
	end

	// completions and responses summed over the banks
	always_comb begin
		req_cnt = '0;
		rsp_cnt = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			req_cnt = req_cnt + BANK_CNT_W'(tx_done[i]);
			rsp_cnt = rsp_cnt + BANK_CNT_W'(b_fire[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
		end else begin
			pending <= pending + PENDING_W'(req_cnt) - PENDING_W'(rsp_cnt);
		end
	end

	assign writes_drained = (pending == '0);

endmodule

// ==== rtl/afu_wrap.sv ====
`timescale 1ns/10ps

module afu_wrap import afu_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   ctrl_awvalid,
	output logic                   ctrl_awready,
	input  logic [CTRL_ADDR_W-1:0] ctrl_awaddr,
	input  logic                   ctrl_wvalid,
	output logic                   ctrl_wready,
	input  logic [CTRL_DATA_W-1:0] ctrl_wdata,
	output logic                   ctrl_bvalid,
	input  logic                   ctrl_bready,
	input  logic                   ctrl_arvalid,
	output logic                   ctrl_arready,
	input  logic [CTRL_ADDR_W-1:0] ctrl_araddr,
	output logic                   ctrl_rvalid,
	input  logic                   ctrl_rready,
	output logic [CTRL_DATA_W-1:0] ctrl_rdata,

	input  logic [NUM_BANKS-1:0]   mem_awvalid,
	input  logic [NUM_BANKS-1:0]   mem_awready,
	input  logic [NUM_BANKS-1:0]   mem_wvalid,
	input  logic [NUM_BANKS-1:0]   mem_wready,
	input  logic [NUM_BANKS-1:0]   mem_bvalid,
	input  logic [NUM_BANKS-1:0]   mem_bready,

	input  logic                   core_busy,
	output logic                   core_reset,

	output logic                   dcr_wr_valid,
	output logic [DCR_ADDR_W-1:0]  dcr_wr_addr,
	output logic [DCR_DATA_W-1:0]  dcr_wr_data,

	output logic                   interrupt
);

	logic               ap_start;
	logic               ap_ctrl_read;
	logic               ap_done;
	logic               writes_drained;
	logic [STATE_W-1:0] run_state;

	afu_ctrl_regs i_ctrl_regs (
		.clk          (clk),
		.reset        (reset),
		.ctrl_awvalid (ctrl_awvalid),
		.ctrl_awready (ctrl_awready),
		.ctrl_awaddr  (ctrl_awaddr),
		.ctrl_wvalid  (ctrl_wvalid),
		.ctrl_wready  (ctrl_wready),
		.ctrl_wdata   (ctrl_wdata),
		.ctrl_bvalid  (ctrl_bvalid),
		.ctrl_bready  (ctrl_bready),
		.ctrl_arvalid (ctrl_arvalid),
		.ctrl_arready (ctrl_arready),
		.ctrl_araddr  (ctrl_araddr),
		.ctrl_rvalid  (ctrl_rvalid),
		.ctrl_rready  (ctrl_rready),
		.ctrl_rdata   (ctrl_rdata),
		.run_state    (run_state),
		.ap_done      (ap_done),
		.ap_start     (ap_start),
		.ap_ctrl_read (ap_ctrl_read),
		.dcr_wr_valid (dcr_wr_valid),
		.dcr_wr_addr  (dcr_wr_addr),
		.dcr_wr_data  (dcr_wr_data),
		.interrupt    (interrupt)
	);

	afu_run_seq i_run_seq (
		.clk            (clk),
		.reset          (reset),
		.ap_start       (ap_start),
		.ap_ctrl_read   (ap_ctrl_read),
		.core_busy      (core_busy),
		.writes_drained (writes_drained),
		.run_state      (run_state),
		.ap_done        (ap_done),
		.core_reset     (core_reset)
	);

	afu_write_tracker i_write_tracker (
		.clk            (clk),
		.reset          (reset),
		.mem_awvalid    (mem_awvalid),
		.mem_awready    (mem_awready),
		.mem_wvalid     (mem_wvalid),
		.mem_wready     (mem_wready),
		.mem_bvalid     (mem_bvalid),
		.mem_bready     (mem_bready),
		.writes_drained (writes_drained)
	);

endmodule

// ==== verif/afu_assert.sv ====
`timescale 1ns/10ps

module afu_assert import afu_pkg::*; (
	input logic                 clk,
	input logic                 reset,
	input logic                 ctrl_bvalid,
	input logic                 ctrl_bready,
	input logic                 ctrl_rvalid,
	input logic                 ctrl_rready,
	input logic                 dcr_wr_valid,
	input logic                 core_reset,
	input logic [STATE_W-1:0]   run_state,
	input logic                 ap_done,
	input logic [NUM_BANKS-1:0] mem_bvalid,
	input logic [NUM_BANKS-1:0] mem_bready
);

	// responses stay up until taken
	bvalid_hold: assert property (@(posedge clk) disable iff (reset)
		ctrl_bvalid && !ctrl_bready |=> ctrl_bvalid)
		else $error("bvalid dropped before bready");

	rvalid_hold: assert property (@(posedge clk) disable iff (reset)
		ctrl_rvalid && !ctrl_rready |=> ctrl_rvalid)
		else $error("rvalid dropped before rready");

	dcr_pulse: assert property (@(posedge clk) disable iff (reset)
		dcr_wr_valid |=> !dcr_wr_valid)
		else $error("dcr strobe longer than one cycle");

	idle_reset: assert property (@(posedge clk) disable iff (reset)
		run_state == ST_IDLE |-> core_reset)
		else $error("core out of reset while idle");

	// no write may still be answered while done is shown
	done_drained: assert property (@(posedge clk) disable iff (reset)
		ap_done |-> !(|(mem_bvalid & mem_bready)))
		else $error("write response arrived while done was reported");

endmodule

bind afu_wrap afu_assert i_assert (
	.clk          (clk),
	.reset        (reset),
	.ctrl_bvalid  (ctrl_bvalid),
	.ctrl_bready  (ctrl_bready),
	.ctrl_rvalid  (ctrl_rvalid),
	.ctrl_rready  (ctrl_rready),
	.dcr_wr_valid (dcr_wr_valid),
	.core_reset   (core_reset),
	.run_state    (run_state),
	.ap_done      (ap_done),
	.mem_bvalid   (mem_bvalid),
	.mem_bready   (mem_bready)
);

// ==== verif/afu_tb.sv ====
`timescale 1ns/10ps

module afu_tb import afu_pkg::*; ();

	localparam int DCR_TEST_CYCLES = 400;
	localparam int RUN_CYCLES      = 200;
	localparam int RUN_COUNT       = 8;
	localparam int TIMEOUT_CYCLES  = 5 * (DCR_TEST_CYCLES + RUN_COUNT * RUN_CYCLES);

	logic clk = 1'b0;
	logic reset;
	logic ctrl_awvalid, ctrl_awready, ctrl_wvalid, ctrl_wready, ctrl_bvalid, ctrl_bready;
	logic ctrl_arvalid, ctrl_arready, ctrl_rvalid, ctrl_rready;
	logic [CTRL_ADDR_W-1:0] ctrl_awaddr, ctrl_araddr;
	logic [CTRL_DATA_W-1:0] ctrl_wdata, ctrl_rdata;
	logic [NUM_BANKS-1:0] mem_awvalid, mem_awready, mem_wvalid, mem_wready;
	logic [NUM_BANKS-1:0] mem_bvalid, mem_bready;
	logic core_busy, core_reset, dcr_wr_valid, interrupt;
	logic [DCR_ADDR_W-1:0] dcr_wr_addr;
	logic [DCR_DATA_W-1:0] dcr_wr_data;

	logic [31:0] rng_state = 32'h85e267db;
	int cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	// reference model state
	logic ref_gie = 1'b0;
	logic ref_ier = 1'b0;
	logic [DCR_ADDR_W-1:0] ref_dcr_addr = '0;
	int aw_cnt[NUM_BANKS] = '{default: 0};
	int w_cnt[NUM_BANKS] = '{default: 0};
	int b_cnt[NUM_BANKS] = '{default: 0};
	int model_pending = 0;
	// observed events
	int strobe_count = 0;
	logic [DCR_ADDR_W-1:0] last_dcr_addr;
	logic [DCR_DATA_W-1:0] last_dcr_data;
	logic core_reset_q = 1'b0;
	int reset_fall_cycle = -1;
	logic irq_seen = 1'b0;
	int busy_low_cycle = 32'h3fff_ffff;
	int last_write_cycle, snap_pending, snap_cycle;

	afu_wrap i_dut (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	always @(posedge clk) begin
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_range(int lo, int hi);
		logic [31:0] r;
		r = next_rand();
		return lo + int'(r[23:8]) % (hi - lo + 1);
	endfunction

	function automatic logic rand_bit();
		logic [31:0] r;
		r = next_rand();
		return r[16];
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERROR at %0t: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic ctrl_write(input logic [CTRL_ADDR_W-1:0] addr, input logic [31:0] data);
		logic hs;
		ctrl_awvalid = 1'b1;
		ctrl_awaddr  = addr;
		ctrl_wvalid  = 1'b1;
		ctrl_wdata   = data;
		while (!(ctrl_awready && ctrl_wready)) tick();
		tick();
		last_write_cycle = cycle;
		ctrl_awvalid = 1'b0;
		ctrl_wvalid  = 1'b0;
		case (addr)
			REG_GIE:      ref_gie = data[0];
			REG_IER:      ref_ier = data[0];
			REG_DCR_ADDR: ref_dcr_addr = data[DCR_ADDR_W-1:0];
			default:      ;
		endcase
		do begin
			ctrl_bready = rand_bit();
			hs = ctrl_bvalid && ctrl_bready;
			tick();
		end while (!hs);
		ctrl_bready = 1'b0;
	endtask

	// pending count and cycle are sampled for the edge that takes the read
	task automatic ctrl_read(input logic [CTRL_ADDR_W-1:0] addr, output logic [31:0] data);
		logic hs;
		ctrl_arvalid = 1'b1;
		ctrl_araddr  = addr;
		while (!ctrl_arready) tick();
		snap_pending = model_pending;
		snap_cycle   = cycle;
		tick();
		ctrl_arvalid = 1'b0;
		do begin
			ctrl_rready = rand_bit();
			data = ctrl_rdata;
			hs = ctrl_rvalid && ctrl_rready;
			tick();
		end while (!hs);
		ctrl_rready = 1'b0;
	endtask

	task automatic run_once();
		ctrl_word_u st;
		logic [31:0] rd;
		int start_cycle;
		busy_low_cycle = 32'h3fff_ffff;
		ctrl_read(REG_CTRL, rd);
		st.raw = rd;
		check_eq(st.status.idle, 1, "idle before start");
		check_eq(st.status.done, 0, "done before start");
		reset_fall_cycle = -1;
		ctrl_write(REG_CTRL, 32'h1);
		start_cycle = last_write_cycle;
		while (reset_fall_cycle < 0) tick();
		check_eq(reset_fall_cycle - start_cycle, 2 + RESET_DELAY, "core reset hold");
		do begin
			repeat (rand_range(0, 3)) tick();
			ctrl_read(REG_CTRL, rd);
			st.raw = rd;
			check_eq(st.status.idle, 0, "idle during run");
			if (snap_pending > 0)
				check_eq(st.status.done, 0, "done with writes outstanding");
			if (snap_pending == 0 && snap_cycle > busy_low_cycle)
				check_eq(st.status.done, 1, "done once core idle and drained");
		end while (!st.status.done);
		ctrl_read(REG_CTRL, rd);
		st.raw = rd;
		check_eq(st.status.idle, 1, "idle after done read");
		check_eq(st.status.done, 0, "done after done read");
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		$display("test %0d (%s): %s", tests_run, name,
			(error_count == errs_before) ? "passed" : "failed");
	endtask

	always @(negedge clk) begin
		if (dcr_wr_valid === 1'b1) begin
			strobe_count++;
			last_dcr_addr = dcr_wr_addr;
			last_dcr_data = dcr_wr_data;
		end
		if (core_reset_q === 1'b1 && core_reset === 1'b0) reset_fall_cycle = cycle;
		core_reset_q = core_reset;
		if (interrupt === 1'b1) irq_seen = 1'b1;
	end

	// reference count of outstanding memory writes
	always @(posedge clk) begin : write_ref
		int total;
		total = 0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (mem_awvalid[b] && mem_awready[b]) aw_cnt[b]++;
			if (mem_wvalid[b] && mem_wready[b]) w_cnt[b]++;
			if (mem_bvalid[b] && mem_bready[b]) b_cnt[b]++;
			total += ((aw_cnt[b] < w_cnt[b]) ? aw_cnt[b] : w_cnt[b]) - b_cnt[b];
		end
		model_pending = total;
	end

	// core and memory model, one write in flight per bank
	initial begin : core_model
		int phase, issue_left;
		int aw_wait[NUM_BANKS], w_wait[NUM_BANKS], resp_owed[NUM_BANKS];
		logic [NUM_BANKS-1:0] txn_active, aw_todo, w_todo;
		mem_awvalid = '0;
		mem_wvalid  = '0;
		mem_bready  = '0;
		mem_awready = '0;
		mem_wready  = '0;
		mem_bvalid  = '0;
		core_busy   = 1'b0;
		phase = 0;
		issue_left = 0;
		txn_active = '0;
		aw_todo = '0;
		w_todo = '0;
		resp_owed = '{default: 0};
		forever begin
			tick();
			for (int b = 0; b < NUM_BANKS; b++) begin
				if (mem_awvalid[b] && mem_awready[b]) begin
					mem_awvalid[b] = 1'b0;
					aw_todo[b] = 1'b0;
				end
				if (mem_wvalid[b] && mem_wready[b]) begin
					mem_wvalid[b] = 1'b0;
					w_todo[b] = 1'b0;
				end
				if (mem_bvalid[b] && mem_bready[b]) begin
					mem_bvalid[b] = 1'b0;
					resp_owed[b]--;
				end
				if (txn_active[b] && !aw_todo[b] && !w_todo[b]) begin
					txn_active[b] = 1'b0;
					resp_owed[b]++;
				end
				if (!txn_active[b] && phase == 1 && rand_range(0, 2) == 0) begin
					txn_active[b] = 1'b1;
					aw_todo[b] = 1'b1;
					w_todo[b] = 1'b1;
					aw_wait[b] = rand_range(0, 2);
					w_wait[b] = rand_range(0, 2);
				end
				if (aw_todo[b] && !mem_awvalid[b]) begin
					if (aw_wait[b] == 0) mem_awvalid[b] = 1'b1;
					else aw_wait[b]--;
				end
				if (w_todo[b] && !mem_wvalid[b]) begin
					if (w_wait[b] == 0) mem_wvalid[b] = 1'b1;
					else w_wait[b]--;
				end
				if (!mem_bvalid[b] && resp_owed[b] > 0 && rand_bit()) mem_bvalid[b] = 1'b1;
				mem_awready[b] = rand_bit();
				mem_wready[b]  = rand_bit();
				mem_bready[b]  = rand_bit();
			end
			case (phase)
				0: if (core_reset === 1'b0) begin
					core_busy = 1'b1;
					issue_left = rand_range(10, 40);
					phase = 1;
				end
				1: if (issue_left == 0) phase = 2; else issue_left--;
				// requests finish before busy drops, responses may still be owed
				2: if (txn_active == '0) begin
					core_busy = 1'b0;
					busy_low_cycle = cycle;
					phase = 3;
				end
				default: if (core_reset === 1'b1) phase = 0;
			endcase
		end
	end

	initial begin : stimulus
		int errs, count0;
		logic [31:0] rd, a, d;
		reset = 1'b1;
		ctrl_awvalid = 1'b0;
		ctrl_awaddr  = '0;
		ctrl_wvalid  = 1'b0;
		ctrl_wdata   = '0;
		ctrl_bready  = 1'b0;
		ctrl_arvalid = 1'b0;
		ctrl_araddr  = '0;
		ctrl_rready  = 1'b0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;

		errs = error_count;
		check_eq({ctrl_awready, ctrl_wready, ctrl_arready}, 3'b111, "readies after reset");
		check_eq({ctrl_bvalid, ctrl_rvalid, dcr_wr_valid, interrupt}, 4'b0000,
			"valids after reset");
		check_eq(core_reset, 1, "core reset after reset");
		for (int i = 0; i < 6; i++) begin
			a = rand_range(0, 4095);
			d = next_rand();
			count0 = strobe_count;
			ctrl_write(REG_DCR_ADDR, a);
			check_eq(strobe_count, count0, "strobe on address write");
			ctrl_write(REG_DCR_DATA, d);
			check_eq(strobe_count, count0 + 1, "strobes per data write");
			check_eq(last_dcr_addr, a, "dcr address");
			check_eq(last_dcr_data, d, "dcr data");
			ctrl_write(REG_GIE, {31'b0, rand_bit()});
			ctrl_write(REG_IER, {31'b0, rand_bit()});
			ctrl_read(REG_GIE, rd);
			check_eq(rd, ref_gie, "gie readback");
			ctrl_read(REG_IER, rd);
			check_eq(rd, ref_ier, "ier readback");
			ctrl_read(REG_DCR_ADDR, rd);
			check_eq(rd, ref_dcr_addr, "dcr address readback");
		end
		finish_test("dcr and registers", errs);

		errs = error_count;
		run_once();
		finish_test("start and core reset timing", errs);

		errs = error_count;
		run_once();
		finish_test("done status", errs);

		errs = error_count;
		// status left over from the earlier runs is cleared first
		ctrl_write(REG_ISR, 32'h1);
		ctrl_write(REG_GIE, 32'h1);
		ctrl_write(REG_IER, 32'h1);
		check_eq(interrupt, 0, "interrupt before run");
		run_once();
		check_eq(interrupt, 1, "interrupt after done");
		ctrl_read(REG_ISR, rd);
		check_eq(rd, 1, "isr after done");
		ctrl_write(REG_ISR, 32'h1);
		tick();
		check_eq(interrupt, 0, "interrupt after isr clear");
		ctrl_write(REG_IER, 32'h0);
		irq_seen = 1'b0;
		run_once();
		tick();
		check_eq(irq_seen, 0, "interrupt with ier clear");
		ctrl_read(REG_ISR, rd);
		check_eq(rd, 1, "isr with ier clear");
		ctrl_write(REG_ISR, 32'h1);
		finish_test("interrupt", errs);

		errs = error_count;
		repeat (4) run_once();
		finish_test("repeated runs under back-pressure", errs);

		$display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
rtl/afu_pkg.sv
rtl/afu_ctrl_regs.sv
rtl/afu_run_seq.sv
rtl/afu_write_tracker.sv
rtl/afu_wrap.sv
verif/afu_assert.sv
verif/afu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module afu_tb -o afu_sim &&
./obj_dir/afu_sim > sim.log 2>&1 ||
echo "build or simulation did not complete"
grep -qx "TEST OK" sim.log
